/* build.f */
logic/pe_pkg.sv
logic/pe_op_decode.sv
logic/fp_add_unit.sv
logic/fp_mul_unit.sv
logic/fp_accumulator.sv
logic/pe_result_align.sv
logic/pe_top.sv
verification/pe_checker.sv
verification/pe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PE testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module pe_tb -f build.f -o pe_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/pe_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^All checks passed$"; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi

/* verification/pe_tb.sv */
`timescale 1ns/1ns

module pe_tb;

    localparam int DRAIN_LIMIT = 64;            // cycles allowed for results to show up

    logic            i_clk;
    logic            i_rst_n;
    pe_pkg::pe_op_e  i_op;
    logic            i_valid1;
    logic            i_valid2;
    pe_pkg::fp32_t   i_data1;
    pe_pkg::fp32_t   i_data2;
    logic            o_valid1;
    pe_pkg::fp32_t   o_data1;
    logic            o_valid2;
    pe_pkg::fp32_t   o_data2;

    int     cycle;                              // posedge count
    int     errors;
    int     checks;
    int     tests;
    integer seed;

    // stimulus table, one entry per beat
    pe_pkg::pe_op_e  tbl_op[$];
    pe_pkg::fp32_t   tbl_a[$];
    pe_pkg::fp32_t   tbl_b[$];
    pe_pkg::fp32_t   tbl_res[$];
    logic            tbl_v1[$];
    logic            tbl_v2[$];
    logic            tbl_has_res[$];

    // expected out1/out2 words with the cycle they are due
    pe_pkg::fp32_t   res_q[$];
    int              res_due[$];
    pe_pkg::fp32_t   fwd_q[$];
    int              fwd_due[$];

    pe_top pe_top_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_op     (i_op),
        .i_valid1 (i_valid1),
        .i_valid2 (i_valid2),
        .i_data1  (i_data1),
        .i_data2  (i_data2),
        .o_valid1 (o_valid1),
        .o_data1  (o_data1),
        .o_valid2 (o_valid2),
        .o_data2  (o_data2)
    );

    always #2 i_clk = ~i_clk;                   // 4 ns period

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
    end

    // exact double to single, fraction truncated
    function automatic pe_pkg::fp32_t to_fp32(input real r);
        logic [63:0] d;
        d = $realtobits(r);
        if (d[62:0] == '0) begin
            return '0;                          // both zeros map to +0
        end
        return {d[63], 8'(d[62:52] - 11'd896), d[51:29]};   // rebias 1023 -> 127
    endfunction

    task automatic push_row(input pe_pkg::pe_op_e op, input pe_pkg::fp32_t a,
                            input pe_pkg::fp32_t b, input logic v1, input logic v2,
                            input logic has_res, input pe_pkg::fp32_t res);
        tbl_op.push_back(op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_v1.push_back(v1);
        tbl_v2.push_back(v2);
        tbl_has_res.push_back(has_res);
        tbl_res.push_back(res);
    endtask

    task automatic add_row(input pe_pkg::pe_op_e op, input real a, input real b,
                           input logic v1, input logic v2, input logic has_res,
                           input real res);
        push_row(op, to_fp32(a), to_fp32(b), v1, v2, has_res, to_fp32(res));
    endtask

    task automatic check_result(input pe_pkg::fp32_t got, input pe_pkg::fp32_t want,
                                input int due);
        checks++;
        if (got !== want || cycle != due) begin
            errors++;
            $display("[ERROR] %0t ns: out1 %h at cycle %0d, expected %h at cycle %0d",
                     $time, got, cycle, want, due);
        end
    endtask

    task automatic check_forward(input pe_pkg::fp32_t got, input pe_pkg::fp32_t want,
                                 input int due);
        checks++;
        if (got !== want || cycle != due) begin
            errors++;
            $display("[ERROR] %0t ns: out2 %h at cycle %0d, expected %h at cycle %0d",
                     $time, got, cycle, want, due);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (o_valid1) begin
                if (res_q.size() == 0) begin
                    errors++;
                    $display("out1 gave %h at %0t ns although no result was expected",
                             o_data1, $time);
                end else begin
                    check_result(o_data1, res_q.pop_front(), res_due.pop_front());
                end
            end
            if (o_valid2) begin
                if (fwd_q.size() == 0) begin
                    errors++;
                    $display("out2 forwarded %h at %0t ns although nothing was sent",
                             o_data2, $time);
                end else begin
                    check_forward(o_data2, fwd_q.pop_front(), fwd_due.pop_front());
                end
            end
        end
    end

    task automatic drive_idle();
        i_op     = pe_pkg::OP_NOP;
        i_valid1 = 1'b0;
        i_valid2 = 1'b0;
        i_data1  = '0;
        i_data2  = '0;
    endtask

    task automatic apply_table();
        for (int i = 0; i < tbl_op.size(); i++) begin
            @(negedge i_clk);
            i_op     = tbl_op[i];
            i_data1  = tbl_a[i];
            i_data2  = tbl_b[i];
            i_valid1 = tbl_v1[i];
            i_valid2 = tbl_v2[i];
            if (tbl_v1[i]) begin                 // every operand 1 is forwarded
                fwd_q.push_back(tbl_a[i]);
                fwd_due.push_back(cycle + pe_pkg::PE_LATENCY);
            end
            if (tbl_has_res[i]) begin
                res_q.push_back(tbl_res[i]);
                res_due.push_back(cycle + pe_pkg::PE_LATENCY);
            end
        end
        @(negedge i_clk);
        drive_idle();
        tbl_op.delete();
        tbl_a.delete();
        tbl_b.delete();
        tbl_v1.delete();
        tbl_v2.delete();
        tbl_has_res.delete();
        tbl_res.delete();
    endtask

    task automatic drain(input string name);
        int waited;
        waited = 0;
        while ((res_q.size() != 0 || fwd_q.size() != 0) && waited < DRAIN_LIMIT) begin
            @(negedge i_clk);
            waited++;
        end
        if (res_q.size() != 0 || fwd_q.size() != 0) begin
            errors++;
            $display("test %s timed out with %0d results and %0d forwards never seen",
                     name, res_q.size(), fwd_q.size());
            res_q.delete();
            res_due.delete();
            fwd_q.delete();
            fwd_due.delete();
        end
        repeat (pe_pkg::PE_LATENCY + 2) @(negedge i_clk);   // late strays land in this test
    endtask

    task automatic run_test(input string name);
        int err0;
        int chk0;
        err0 = errors;
        chk0 = checks;
        apply_table();
        drain(name);
        tests++;
        $display("test %-8s %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        i_clk   = 1'b0;
        i_rst_n = 1'b0;
        cycle   = 0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        seed    = 67;
        drive_idle();
        repeat (5) @(posedge i_clk);            // reset over 5 edges
        @(negedge i_clk);
        i_rst_n = 1'b1;

        add_row(pe_pkg::OP_ADD, 3.0, 4.5, 1'b1, 1'b1, 1'b1, 7.5);
        add_row(pe_pkg::OP_ADD, -2.0, 0.5, 1'b1, 1'b1, 1'b1, -1.5);
        add_row(pe_pkg::OP_ADD, 1.5, 1.5, 1'b1, 1'b1, 1'b1, 3.0);     // carry out
        add_row(pe_pkg::OP_ADD, 1.0, -1.0, 1'b1, 1'b1, 1'b1, 0.0);    // cancels to zero
        add_row(pe_pkg::OP_ADD, 10.0, 0.25, 1'b1, 1'b1, 1'b1, 10.25);
        add_row(pe_pkg::OP_ADD, 5.0, 5.0, 1'b1, 1'b0, 1'b0, 0.0);     // op 2 missing
        run_test("add");

        add_row(pe_pkg::OP_MUL, 2.5, 4.0, 1'b1, 1'b1, 1'b1, 10.0);
        add_row(pe_pkg::OP_MUL, -3.0, 1.5, 1'b1, 1'b1, 1'b1, -4.5);
        add_row(pe_pkg::OP_MUL, 0.5, 0.5, 1'b1, 1'b1, 1'b1, 0.25);
        add_row(pe_pkg::OP_MUL, 6.0, 2.0, 1'b1, 1'b0, 1'b0, 0.0);     // one valid only
        add_row(pe_pkg::OP_MUL, 6.0, 2.0, 1'b0, 1'b1, 1'b0, 0.0);
        run_test("mul");

        add_row(pe_pkg::OP_ACC, 1.0, 0.0, 1'b1, 1'b0, 1'b1, 1.0);
        add_row(pe_pkg::OP_ACC, 2.5, 0.0, 1'b1, 1'b0, 1'b1, 3.5);
        add_row(pe_pkg::OP_ACC, 9.0, 0.0, 1'b0, 1'b0, 1'b0, 0.0);     // skipped beat
        add_row(pe_pkg::OP_ACC, 3.0, 0.0, 1'b1, 1'b0, 1'b1, 6.5);
        add_row(pe_pkg::OP_ADD, 1.0, 1.0, 1'b1, 1'b1, 1'b1, 2.0);     // breaks the run
        add_row(pe_pkg::OP_ACC, 4.0, 0.0, 1'b1, 1'b0, 1'b1, 4.0);     // new run
        add_row(pe_pkg::OP_ACC, -6.5, 0.0, 1'b1, 1'b0, 1'b1, -2.5);
        add_row(pe_pkg::OP_ACC, 0.25, 0.0, 1'b1, 1'b0, 1'b1, -2.25);
        run_test("acc");

        add_row(pe_pkg::OP_MACC, 2.0, 3.0, 1'b1, 1'b1, 1'b1, 6.0);
        add_row(pe_pkg::OP_MACC, 1.0, 4.0, 1'b1, 1'b1, 1'b1, 10.0);
        add_row(pe_pkg::OP_MACC, 0.5, 4.0, 1'b1, 1'b1, 1'b1, 12.0);
        add_row(pe_pkg::OP_MACC, -2.0, 1.5, 1'b1, 1'b1, 1'b1, 9.0);
        add_row(pe_pkg::OP_MUL, 2.0, 2.0, 1'b1, 1'b1, 1'b1, 4.0);     // plain product between
        add_row(pe_pkg::OP_MACC, 1.0, 1.0, 1'b1, 1'b1, 1'b1, 1.0);    // sum restarts
        run_test("macc");

        add_row(pe_pkg::OP_NOP, 5.0, 6.0, 1'b1, 1'b1, 1'b0, 0.0);
        add_row(pe_pkg::pe_op_e'(3'b101), 7.0, 8.0, 1'b1, 1'b1, 1'b0, 0.0);
        add_row(pe_pkg::pe_op_e'(3'b111), -1.0, 2.0, 1'b1, 1'b1, 1'b0, 0.0);
        add_row(pe_pkg::OP_NOP, 3.0, 3.0, 1'b0, 1'b1, 1'b0, 0.0);     // nothing to forward
        for (int i = 0; i < 12; i++) begin
            push_row(pe_pkg::OP_NOP, pe_pkg::fp32_t'($random(seed)),
                     pe_pkg::fp32_t'($random(seed)), 1'b1, 1'b1, 1'b0, '0);
        end
        run_test("nop_fwd");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verification/pe_checker.sv */
`timescale 1ns/1ns

module pe_checker (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  pe_pkg::pe_op_e   i_op,
    input  logic             i_valid1,
    input  logic             i_valid2,
    input  logic             o_valid1,
    input  logic             o_valid2
);

    logic beat_fires;   // add or mul beat with both operands

    assign beat_fires = i_valid1 & i_valid2 &
                        ((i_op == pe_pkg::OP_ADD) | (i_op == pe_pkg::OP_MUL));

    valid_low_after_reset: assert property (@(posedge i_clk)
        !i_rst_n |=> (!o_valid1 && !o_valid2))
        else $error("output valid high after a reset edge");

    // forward channel is a plain 8 cycle delay of valid 1
    forward_valid_delay: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_rst_n, pe_pkg::PE_LATENCY) |-> (o_valid2 == $past(i_valid1, pe_pkg::PE_LATENCY)))
        else $error("o_valid2 does not follow i_valid1 by the PE latency");

    add_mul_gives_result: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        beat_fires |-> ##8 o_valid1)
        else $error("add or mul beat gave no out1 result 8 cycles later");

endmodule

bind pe_top pe_checker pe_checker_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_op     (i_op),
    .i_valid1 (i_valid1),
    .i_valid2 (i_valid2),
    .o_valid1 (o_valid1),
    .o_valid2 (o_valid2)
);

/* logic/pe_top.sv */
`timescale 1ns/1ns

module pe_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  pe_pkg::pe_op_e   i_op,
    input  logic             i_valid1,
    input  logic             i_valid2,
    input  pe_pkg::fp32_t    i_data1,
    input  pe_pkg::fp32_t    i_data2,
    output logic             o_valid1,
    output pe_pkg::fp32_t    o_data1,
    output logic             o_valid2,
    output pe_pkg::fp32_t    o_data2
);

    logic            add_fire, mul_fire, mul_to_acc, acc_fire, acc_clr;
    logic            add_valid;
    pe_pkg::fp32_t   add_sum;
    logic            mul_valid, mul_tag;
    pe_pkg::fp32_t   mul_prod;
    logic [1:0]      acc_valid;         // [1] flags a macc sum
    pe_pkg::fp32_t   acc_sum;

    pe_op_decode u_decode (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_op         (i_op),
        .i_valid1     (i_valid1),
        .i_valid2     (i_valid2),
        .o_add_fire   (add_fire),
        .o_mul_fire   (mul_fire),
        .o_mul_to_acc (mul_to_acc),
        .o_acc_fire   (acc_fire),
        .o_acc_clr    (acc_clr)
    );

    fp_add_unit u_add (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_fire  (add_fire),
        .i_a     (i_data1),
        .i_b     (i_data2),
        .o_valid (add_valid),
        .o_sum   (add_sum)
    );

    fp_mul_unit u_mul (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_fire  (mul_fire),
        .i_tag   (mul_to_acc),
        .i_a     (i_data1),
        .i_b     (i_data2),
        .o_valid (mul_valid),
        .o_tag   (mul_tag),
        .o_prod  (mul_prod)
    );

    fp_accumulator u_acc (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_clr        (acc_clr),
        .i_sel_prod   (mul_to_acc),     // delayed inside to meet the product
        .i_in_valid   (acc_fire),
        .i_in         (i_data1),
        .i_prod_valid (mul_valid),
        .i_prod       (mul_prod),
        .o_valid      (acc_valid),
        .o_sum        (acc_sum)
    );

    pe_result_align u_align (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_add_valid (add_valid),
        .i_add       (add_sum),
        .i_mul_valid (mul_valid),
        .i_mul_tag   (mul_tag),
        .i_mul       (mul_prod),
        .i_acc_valid (acc_valid[0]),
        .i_acc_macc  (acc_valid[1]),
        .i_acc       (acc_sum),
        .i_fwd_valid (i_valid1),        // operand 1 to the next PE
        .i_fwd       (i_data1),
        .o_valid1    (o_valid1),
        .o_data1     (o_data1),
        .o_valid2    (o_valid2),
        .o_data2     (o_data2)
    );

endmodule

/* logic/pe_result_align.sv */
`timescale 1ns/1ns

module pe_result_align (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_add_valid,
    input  pe_pkg::fp32_t   i_add,
    input  logic            i_mul_valid,
    input  logic            i_mul_tag,      // product headed for the acc
    input  pe_pkg::fp32_t   i_mul,
    input  logic            i_acc_valid,
    input  logic            i_acc_macc,     // sum already at full latency
    input  pe_pkg::fp32_t   i_acc,
    input  logic            i_fwd_valid,
    input  pe_pkg::fp32_t   i_fwd,
    output logic            o_valid1,
    output pe_pkg::fp32_t   o_data1,
    output logic            o_valid2,
    output pe_pkg::fp32_t   o_data2
);

    logic            sel_valid;
    pe_pkg::fp32_t   sel_data;
    logic            macc_hit;

    logic [pe_pkg::ALIGN_LATENCY-1:0] dly_valid;
    pe_pkg::fp32_t                    dly_data [pe_pkg::ALIGN_LATENCY];
    logic [pe_pkg::PE_LATENCY-1:0]    fwd_valid;
    pe_pkg::fp32_t                    fwd_data [pe_pkg::PE_LATENCY];

    // one unit fires per beat, priority only as a guard
    always_comb begin
        sel_valid = 1'b1;
        if (i_add_valid) begin
            sel_data = i_add;
        end else if (i_mul_valid && !i_mul_tag) begin
            sel_data = i_mul;
        end else if (i_acc_valid && !i_acc_macc) begin
            sel_data = i_acc;
        end else begin
            sel_valid = 1'b0;
            sel_data  = i_add;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            dly_valid <= '0;
            fwd_valid <= '0;
        end else begin
            dly_valid <= {dly_valid[pe_pkg::ALIGN_LATENCY-2:0], sel_valid};
            fwd_valid <= {fwd_valid[pe_pkg::PE_LATENCY-2:0], i_fwd_valid};
        end
    end

    always_ff @(posedge i_clk) begin
        dly_data[0] <= sel_data;
        for (int i = 1; i < pe_pkg::ALIGN_LATENCY; i++) begin
            dly_data[i] <= dly_data[i-1];
        end
        fwd_data[0] <= i_fwd;
        for (int i = 1; i < pe_pkg::PE_LATENCY; i++) begin
            fwd_data[i] <= fwd_data[i-1];
        end
    end

    assign macc_hit = i_acc_valid & i_acc_macc;    // bypass the align delay
    assign o_valid1 = macc_hit | dly_valid[pe_pkg::ALIGN_LATENCY-1];
    assign o_data1  = macc_hit ? i_acc : dly_data[pe_pkg::ALIGN_LATENCY-1];
    assign o_valid2 = fwd_valid[pe_pkg::PE_LATENCY-1];
    assign o_data2  = fwd_data[pe_pkg::PE_LATENCY-1];

endmodule

/* logic/fp_accumulator.sv */
`timescale 1ns/1ns

module fp_accumulator (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_clr,          // first cycle of an acc/macc run
    input  logic            i_sel_prod,     // opcode is macc now
    input  logic            i_in_valid,
    input  pe_pkg::fp32_t   i_in,
    input  logic            i_prod_valid,
    input  pe_pkg::fp32_t   i_prod,
    output logic [1:0]      o_valid,        // [0] new sum, [1] macc sum
    output pe_pkg::fp32_t   o_sum
);

    // macc mode and clear, delayed to line up with multiplier output
    logic [pe_pkg::UNIT_LATENCY-1:0] mode_dly;
    logic [pe_pkg::UNIT_LATENCY-1:0] clr_dly;

    logic                        sel_d;     // product path active
    logic                        take;
    logic                        clr_now;
    pe_pkg::fp32_t               src;
    pe_pkg::fp_exp_t             src_exp;
    pe_pkg::fp_man_t             src_man;
    logic [pe_pkg::ACC_WIDTH-1:0] src_mag;

    logic                        s1_valid, s1_clr, s1_macc;
    pe_pkg::acc_fix_t            s1_fix;
    logic                        s2_valid, s2_macc;
    pe_pkg::acc_fix_t            sum;       // running sum
    logic [pe_pkg::ACC_WIDTH-1:0] sum_mag;
    logic                        s3_valid, s3_macc, s3_sign;
    logic [pe_pkg::ACC_WIDTH-1:0] s3_mag;
    logic [5:0]                  s3_lz;
    logic [pe_pkg::ACC_WIDTH-1:0] s3_norm;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            mode_dly <= '0;
            clr_dly  <= '0;
        end else begin
            mode_dly <= {mode_dly[pe_pkg::UNIT_LATENCY-2:0], i_sel_prod};
            clr_dly  <= {clr_dly[pe_pkg::UNIT_LATENCY-2:0], i_clr & i_sel_prod};
        end
    end

    assign sel_d   = mode_dly[pe_pkg::UNIT_LATENCY-1];
    assign take    = sel_d ? i_prod_valid : i_in_valid;
    assign clr_now = sel_d ? clr_dly[pe_pkg::UNIT_LATENCY-1] : (i_clr & ~i_sel_prod);
    assign src     = sel_d ? i_prod : i_in;
    assign src_exp = src[30:23];
    assign src_man = {1'b1, src[22:0]};

    // float to fixed, shift on exponent
    always_comb begin
        if (src_exp == '0) begin
            src_mag = '0;                                   // zero or denormal
        end else if (src_exp >= pe_pkg::ACC_EXP_ZERO) begin
            src_mag = {24'b0, src_man} << (src_exp - pe_pkg::ACC_EXP_ZERO);
        end else begin
            src_mag = {24'b0, src_man} >> (pe_pkg::ACC_EXP_ZERO - src_exp);   // truncates
        end
    end

    assign sum_mag = sum[pe_pkg::ACC_WIDTH-1] ? -sum : sum;  // abs for repack
    assign s3_norm = s3_mag << s3_lz;                        // leading one to msb

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
            s1_clr   <= 1'b0;
            s1_macc  <= 1'b0;
            s2_valid <= 1'b0;
            s2_macc  <= 1'b0;
            sum      <= '0;
            s3_valid <= 1'b0;
            s3_macc  <= 1'b0;
            o_valid  <= '0;
        end else begin
            s1_valid <= take;
            s1_clr   <= clr_now;
            s1_macc  <= sel_d;
            s2_valid <= s1_valid;
            s2_macc  <= s1_macc;
            if (s1_clr) begin
                sum <= s1_valid ? s1_fix : '0;               // load, drop old run
            end else if (s1_valid) begin
                sum <= sum + s1_fix;
            end
            s3_valid <= s2_valid;
            s3_macc  <= s2_macc;
            o_valid  <= {s3_macc, s3_valid};
        end
    end

    always_ff @(posedge i_clk) begin
        s1_fix  <= src[31] ? -pe_pkg::acc_fix_t'(src_mag) : pe_pkg::acc_fix_t'(src_mag);
        s3_sign <= sum[pe_pkg::ACC_WIDTH-1];
        s3_mag  <= sum_mag;
        s3_lz   <= pe_pkg::count_lz(sum_mag);
        if (s3_mag == '0) begin
            o_sum <= '0;
        end else begin
            // msb weight 2^31, exponent falls by one per leading zero
            o_sum <= {s3_sign, pe_pkg::ACC_EXP_ZERO + 8'd24 - {2'b00, s3_lz},
                      s3_norm[46:24]};
        end
    end

endmodule

/* logic/fp_mul_unit.sv */
`timescale 1ns/1ns

module fp_mul_unit (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_fire,
    input  logic            i_tag,      // result is for the accumulator
    input  pe_pkg::fp32_t   i_a,
    input  pe_pkg::fp32_t   i_b,
    output logic            o_valid,
    output logic            o_tag,
    output pe_pkg::fp32_t   o_prod
);

    logic [pe_pkg::UNIT_LATENCY-1:0] vld;   // valid per stage
    logic [pe_pkg::UNIT_LATENCY-1:0] tag;   // tag rides with valid

    pe_pkg::fp_exp_t   ea, eb;
    logic              s1_sign, s2_sign, s3_sign;
    logic              s1_zero, s2_zero, s3_zero;     // either input zero
    logic signed [9:0] s1_exp, s2_exp, s3_exp;        // unbiased sum plus bias
    pe_pkg::fp_man_t   s1_ma, s1_mb;
    logic [35:0]       s2_pp_lo, s2_pp_hi;            // 24x12 partials
    logic [47:0]       s3_prod;
    logic signed [9:0] exp_n;                         // after 1 bit normalize

    assign ea = i_a[30:23];
    assign eb = i_b[30:23];

    assign exp_n = s3_exp + (s3_prod[47] ? 10'sd1 : 10'sd0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            vld <= '0;
            tag <= '0;
        end else begin
            vld <= {vld[pe_pkg::UNIT_LATENCY-2:0], i_fire};
            tag <= {tag[pe_pkg::UNIT_LATENCY-2:0], i_tag & i_fire};
        end
    end

    always_ff @(posedge i_clk) begin
        s1_sign <= i_a[31] ^ i_b[31];
        s1_zero <= (ea == '0) || (eb == '0);          // denormals count as zero
        s1_exp  <= $signed({2'b00, ea}) + $signed({2'b00, eb}) - 10'sd127;
        s1_ma   <= {1'b1, i_a[22:0]};
        s1_mb   <= {1'b1, i_b[22:0]};

        s2_sign  <= s1_sign;
        s2_zero  <= s1_zero;
        s2_exp   <= s1_exp;
        s2_pp_lo <= s1_ma * s1_mb[11:0];
        s2_pp_hi <= s1_ma * s1_mb[23:12];

        s3_sign <= s2_sign;
        s3_zero <= s2_zero;
        s3_exp  <= s2_exp;
        s3_prod <= {12'b0, s2_pp_lo} + {s2_pp_hi, 12'b0};

        if (s3_zero || (exp_n <= 10'sd0)) begin
            o_prod <= '0;                            // flush
        end else if (s3_prod[47]) begin
            o_prod <= {s3_sign, exp_n[7:0], s3_prod[46:24]};
        end else begin
            o_prod <= {s3_sign, exp_n[7:0], s3_prod[45:23]};
        end
    end

    assign o_valid = vld[pe_pkg::UNIT_LATENCY-1];
    assign o_tag   = tag[pe_pkg::UNIT_LATENCY-1];

endmodule

/* logic/fp_add_unit.sv */
`timescale 1ns/1ns

module fp_add_unit (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_fire,
    input  pe_pkg::fp32_t   i_a,
    input  pe_pkg::fp32_t   i_b,
    output logic            o_valid,
    output pe_pkg::fp32_t   o_sum
);

    logic [pe_pkg::UNIT_LATENCY-1:0] vld;   // valid shift with one bit per stage

    logic             a_big;                // |a| >= |b|
    pe_pkg::fp32_t    big, small_op;
    pe_pkg::fp_man_t  big_man, small_man;

    // stage 1 swapped operands
    logic             s1_sign_big, s1_sign_small;
    pe_pkg::fp_exp_t  s1_exp;
    pe_pkg::fp_man_t  s1_man_big, s1_man_small;
    pe_pkg::fp_exp_t  s1_shift;

    // stage 2 raw sum
    logic             s2_sign;
    pe_pkg::fp_exp_t  s2_exp;
    logic [24:0]      s2_sum;               // one carry bit
    logic [5:0]       s2_lz;

    // stage 3 normalized
    logic             s3_sign;
    logic             s3_zero;
    logic signed [9:0] s3_exp;              // room for underflow
    pe_pkg::fp_man_t  s3_man;

    assign a_big     = i_a[30:0] >= i_b[30:0];          // field compare works on normals
    assign big       = a_big ? i_a : i_b;
    assign small_op  = a_big ? i_b : i_a;
    assign big_man   = (big[30:23] != '0) ? {1'b1, big[22:0]} : '0;     // flush denormals
    assign small_man = (small_op[30:23] != '0) ? {1'b1, small_op[22:0]} : '0;

    assign s2_lz = pe_pkg::count_lz({s2_sum[23:0], 24'b0});

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[pe_pkg::UNIT_LATENCY-2:0], i_fire};
        end
    end

    always_ff @(posedge i_clk) begin
        // stage 1 unpack and swap
        s1_sign_big   <= big[31];
        s1_sign_small <= small_op[31];
        s1_exp        <= big[30:23];
        s1_man_big    <= big_man;
        s1_man_small  <= small_man;
        s1_shift      <= big[30:23] - small_op[30:23];

        // stage 2 align and add with shifted-out bits truncated
        s2_sign <= s1_sign_big;
        s2_exp  <= s1_exp;
        if (s1_sign_big != s1_sign_small) begin
            s2_sum <= {1'b0, s1_man_big} - {1'b0, s1_man_small >> s1_shift};
        end else begin
            s2_sum <= {1'b0, s1_man_big} + {1'b0, s1_man_small >> s1_shift};
        end

        // stage 3 leading one
        s3_sign <= s2_sign;
        s3_zero <= (s2_sum == '0);
        if (s2_sum[24]) begin
            s3_man <= s2_sum[24:1];             // carry out so shift right one
            s3_exp <= $signed({2'b00, s2_exp}) + 10'sd1;
        end else begin
            s3_man <= s2_sum[23:0] << s2_lz;
            s3_exp <= $signed({2'b00, s2_exp}) - $signed({4'b0000, s2_lz});
        end

        // stage 4 pack and flush underflow to zero
        if (s3_zero || (s3_exp <= 10'sd0)) begin
            o_sum <= '0;
        end else begin
            o_sum <= {s3_sign, s3_exp[7:0], s3_man[22:0]};
        end
    end

    assign o_valid = vld[pe_pkg::UNIT_LATENCY-1];

endmodule

/* logic/pe_op_decode.sv */
`timescale 1ns/1ns

module pe_op_decode (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  pe_pkg::pe_op_e   i_op,
    input  logic             i_valid1,
    input  logic             i_valid2,
    output logic             o_add_fire,
    output logic             o_mul_fire,
    output logic             o_mul_to_acc,
    output logic             o_acc_fire,
    output logic             o_acc_clr
);

    logic both_valid;   // add/mul need both operands
    logic acc_mode;     // acc or macc this cycle
    logic acc_mode_q;   // acc or macc last cycle

    assign both_valid = i_valid1 & i_valid2;
    assign acc_mode   = (i_op == pe_pkg::OP_ACC) || (i_op == pe_pkg::OP_MACC);

    assign o_add_fire   = both_valid & (i_op == pe_pkg::OP_ADD);
    assign o_mul_fire   = both_valid & ((i_op == pe_pkg::OP_MUL) || (i_op == pe_pkg::OP_MACC));
    assign o_mul_to_acc = (i_op == pe_pkg::OP_MACC);           // tag products for the acc
    assign o_acc_fire   = i_valid1 & (i_op == pe_pkg::OP_ACC); // operand 1 only
    assign o_acc_clr    = acc_mode & ~acc_mode_q;              // new run starts

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            acc_mode_q <= 1'b0;
        end else begin
            acc_mode_q <= acc_mode;
        end
    end

endmodule

/* logic/pe_pkg.sv */
package pe_pkg;

    typedef logic [31:0] fp32_t;                // ieee single word
    typedef logic [7:0]  fp_exp_t;              // biased exponent
    typedef logic [23:0] fp_man_t;              // mantissa incl hidden bit

    localparam int ACC_WIDTH     = 48;          // fixed point sum width
    localparam int ACC_FRAC_BITS = 16;          // bits below the binary point
    typedef logic signed [ACC_WIDTH-1:0] acc_fix_t;

    // biased exponent whose mantissa lsb lands on the fixed point lsb
    localparam fp_exp_t ACC_EXP_ZERO = fp_exp_t'(150 - ACC_FRAC_BITS);

    typedef enum logic [2:0] {
        OP_ADD  = 3'b000,
        OP_ACC  = 3'b001,
        OP_MUL  = 3'b010,
        OP_MACC = 3'b011,
        OP_NOP  = 3'b100                        // 101..111 also idle
    } pe_op_e;

    localparam int UNIT_LATENCY  = 4;           // add, mul and acc depth
    localparam int ALIGN_LATENCY = 4;           // extra delay on unit results
    localparam int PE_LATENCY    = 8;           // input to out1/out2

    // leading zeros of a 48 bit word, 48 when all zero
    function automatic logic [5:0] count_lz(input logic [47:0] v);
        logic [5:0] n;
        n = 6'd48;
        for (int i = 0; i < 48; i++) begin
            if (v[i]) begin
                n = 6'(47 - i);                 // highest set bit wins
            end
        end
        return n;
    endfunction

endpackage
